// ==== source/ibuf_pkg.sv ====
`default_nettype none

package ibuf_pkg;

    localparam int NUM_SLOTS = 4;
    localparam int LINE_BITS = 128;
    localparam int BIP_BITS  = 6;

    // slot parity masks, slot index bit 0 picks the bank
    localparam logic [NUM_SLOTS-1:0] EVEN_SLOTS = 4'b0101;
    localparam logic [NUM_SLOTS-1:0] ODD_SLOTS  = 4'b1010;

    typedef logic [LINE_BITS-1:0] line_t;

    // bit 1 is the even bank, bit 0 the odd bank
    typedef enum logic [1:0] {
        LOAD_NONE = 2'd0,
        LOAD_ODD  = 2'd1,
        LOAD_EVEN = 2'd2,
        LOAD_BOTH = 2'd3
    } load_mode_t;

    typedef struct packed {
        line_t      even_line;
        line_t      odd_line;
        logic       even_miss;
        logic       odd_miss;
        logic [1:0] even_pos;   // always an even slot
        logic [1:0] odd_pos;    // always an odd slot
    } fetch_pair_t;

    typedef struct packed {
        logic                init;
        logic                resteer;
        logic                br_fix;     // taken / not-taken correction
        logic [BIP_BITS-1:0] target_bip;
    } redirect_t;

endpackage

`default_nettype wire

// ==== source/ibuf_load_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_load_ctrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  ibuf_pkg::redirect_t           redirect,
    input  wire [ibuf_pkg::NUM_SLOTS-1:0] valid,
    input  wire                           even_miss,
    input  wire                           odd_miss,
    output ibuf_pkg::load_mode_t          load_mode
);

    logic                 flush;
    logic                 even_free;
    logic                 odd_free;
    ibuf_pkg::load_mode_t mode_d;
    ibuf_pkg::load_mode_t mode_q;
    ibuf_pkg::load_mode_t base_mode;

    assign flush = redirect.init | redirect.resteer | redirect.br_fix;

    // any invalid slot of each parity
    assign even_free = |(~valid & ibuf_pkg::EVEN_SLOTS);
    assign odd_free  = |(~valid & ibuf_pkg::ODD_SLOTS);

    always_comb begin
        if (even_free && odd_free) begin
            mode_d = ibuf_pkg::LOAD_BOTH;
        end else if (even_free) begin
            mode_d = ibuf_pkg::LOAD_EVEN;
        end else if (odd_free) begin
            mode_d = ibuf_pkg::LOAD_ODD;
        end else begin
            mode_d = ibuf_pkg::LOAD_NONE;   // buffer full
        end
    end

    // a miss on either bank holds the mode until the cache delivers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= ibuf_pkg::LOAD_NONE;
        end else if (!even_miss && !odd_miss) begin
            mode_q <= mode_d;
        end
    end

    assign base_mode = flush ? ibuf_pkg::LOAD_BOTH : mode_q;

    // drop the half of the mode whose bank missed
    assign load_mode = ibuf_pkg::load_mode_t'(base_mode & {~even_miss, ~odd_miss});

endmodule

`default_nettype wire

// ==== source/ibuf_slot_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_slot_select (
    input  ibuf_pkg::load_mode_t           load_mode,
    input  wire [1:0]                      even_pos,
    input  wire [1:0]                      odd_pos,
    input  wire [ibuf_pkg::NUM_SLOTS-1:0]  valid,
    input  wire                            flush,
    output logic [ibuf_pkg::NUM_SLOTS-1:0] load_en,
    output logic                           even_loaded,
    output logic                           odd_loaded
);

    logic                          want_even;
    logic                          want_odd;
    logic [ibuf_pkg::NUM_SLOTS-1:0] even_hot;
    logic [ibuf_pkg::NUM_SLOTS-1:0] odd_hot;
    logic [ibuf_pkg::NUM_SLOTS-1:0] avail;

    assign want_even = (load_mode == ibuf_pkg::LOAD_EVEN) || (load_mode == ibuf_pkg::LOAD_BOTH);
    assign want_odd  = (load_mode == ibuf_pkg::LOAD_ODD) || (load_mode == ibuf_pkg::LOAD_BOTH);

    // one-hot slot of each bank, kept to its own parity
    assign even_hot = (4'b0001 << even_pos) & ibuf_pkg::EVEN_SLOTS;
    assign odd_hot  = (4'b0001 << odd_pos) & ibuf_pkg::ODD_SLOTS;

    // a flush may overwrite anything, otherwise only empty slots
    assign avail = flush ? {ibuf_pkg::NUM_SLOTS{1'b1}} : ~valid;

    assign load_en = ((want_even ? even_hot : 4'b0000) | (want_odd ? odd_hot : 4'b0000)) & avail;

    assign even_loaded = |(load_en & ibuf_pkg::EVEN_SLOTS);
    assign odd_loaded  = |(load_en & ibuf_pkg::ODD_SLOTS);

endmodule

`default_nettype wire

// ==== source/ibuf_retire_track.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_retire_track (
    input  wire                              clk,
    input  wire                              rst_n,
    input  ibuf_pkg::redirect_t              redirect,
    input  wire                              consume,
    input  wire [3:0]                        consume_len,
    output logic [ibuf_pkg::BIP_BITS-1:0]    bip,
    output logic                             flush,
    output logic [ibuf_pkg::NUM_SLOTS-1:0]   free_en
);

    logic [ibuf_pkg::BIP_BITS-1:0] bip_next;
    logic                          crossed;

    assign flush = redirect.init | redirect.resteer | redirect.br_fix;

    assign bip_next = bip + {2'b00, consume_len};   // wraps over the 64 byte buffer

    // low nibble went backwards, so the pointer left its 16 byte line
    assign crossed = consume && (bip_next[3:0] < bip[3:0]);

    always_comb begin
        if (flush) begin
            free_en = {ibuf_pkg::NUM_SLOTS{1'b1}};
        end else if (crossed) begin
            free_en = 4'b0001 << bip[5:4];
        end else begin
            free_en = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bip <= '0;
        end else if (flush) begin
            bip <= redirect.target_bip;
        end else if (consume) begin
            bip <= bip_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/ibuf_line_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_line_store (
    input  wire                                            clk,
    input  wire                                            rst_n,
    input  ibuf_pkg::fetch_pair_t                          fetch,
    input  wire [ibuf_pkg::NUM_SLOTS-1:0]                  load_en,
    input  wire [ibuf_pkg::NUM_SLOTS-1:0]                  free_en,
    output ibuf_pkg::line_t [ibuf_pkg::NUM_SLOTS-1:0]      lines,
    output logic [ibuf_pkg::NUM_SLOTS-1:0]                 valid
);

    // line payload, odd slots take the odd bank
    always_ff @(posedge clk) begin
        for (int i = 0; i < ibuf_pkg::NUM_SLOTS; i++) begin
            if (load_en[i]) begin
                lines[i] <= (i % 2 == 1) ? fetch.odd_line : fetch.even_line;
            end
        end
    end

    // write wins over free in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            valid <= load_en | (valid & ~free_en);
        end
    end

endmodule

`default_nettype wire

// ==== source/ibuf_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_top (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  ibuf_pkg::fetch_pair_t                      fetch,
    input  ibuf_pkg::redirect_t                        redirect,
    input  wire                                        consume,
    input  wire [3:0]                                  consume_len,
    output ibuf_pkg::line_t [ibuf_pkg::NUM_SLOTS-1:0]  lines,
    output wire [ibuf_pkg::NUM_SLOTS-1:0]              valid,
    output wire [ibuf_pkg::BIP_BITS-1:0]               bip,
    output wire                                        even_loaded,
    output wire                                        odd_loaded
);

    ibuf_pkg::load_mode_t            load_mode;
    wire [ibuf_pkg::NUM_SLOTS-1:0]   load_en;
    wire [ibuf_pkg::NUM_SLOTS-1:0]   free_en;
    wire                             flush;

    ibuf_load_ctrl u_load_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .valid     (valid),
        .even_miss (fetch.even_miss),
        .odd_miss  (fetch.odd_miss),
        .load_mode (load_mode)
    );

    ibuf_slot_select u_slot_select (
        .load_mode   (load_mode),
        .even_pos    (fetch.even_pos),
        .odd_pos     (fetch.odd_pos),
        .valid       (valid),
        .flush       (flush),
        .load_en     (load_en),
        .even_loaded (even_loaded),
        .odd_loaded  (odd_loaded)
    );

    ibuf_retire_track u_retire_track (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .consume     (consume),
        .consume_len (consume_len),
        .bip         (bip),
        .flush       (flush),
        .free_en     (free_en)
    );

    ibuf_line_store u_line_store (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetch   (fetch),
        .load_en (load_en),
        .free_en (free_en),
        .lines   (lines),
        .valid   (valid)
    );

endmodule

`default_nettype wire

// ==== verification/ibuf_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_props (
    input wire                  clk,
    input wire                  rst_n,
    input ibuf_pkg::redirect_t  redirect,
    input wire                  even_miss,
    input wire                  odd_miss,
    input ibuf_pkg::load_mode_t load_mode,
    input ibuf_pkg::load_mode_t mode_q
);

    int unsigned fail_count = 0;   // read by the testbench
    logic        flush;

    assign flush = redirect.init | redirect.resteer | redirect.br_fix;

    // a clean flush always asks for both banks
    a_flush_both: assert property (@(posedge clk) disable iff (!rst_n)
        (flush && !even_miss && !odd_miss) |-> load_mode == ibuf_pkg::LOAD_BOTH)
        else begin
            $error("load_mode is not LOAD_BOTH in a flush cycle without a miss");
            fail_count++;
        end

    a_even_dropped: assert property (@(posedge clk) disable iff (!rst_n)
        even_miss |-> !(load_mode inside {ibuf_pkg::LOAD_EVEN, ibuf_pkg::LOAD_BOTH}))
        else begin
            $error("load_mode includes the even bank while even_miss is set");
            fail_count++;
        end

    a_odd_dropped: assert property (@(posedge clk) disable iff (!rst_n)
        odd_miss |-> !(load_mode inside {ibuf_pkg::LOAD_ODD, ibuf_pkg::LOAD_BOTH}))
        else begin
            $error("load_mode includes the odd bank while odd_miss is set");
            fail_count++;
        end

    // mode register frozen across a miss
    a_hold_on_miss: assert property (@(posedge clk) disable iff (!rst_n)
        (even_miss || odd_miss) |=> $stable(mode_q))
        else begin
            $error("mode register changed after a cycle with a miss");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== verification/ibuf_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // reset held over 10 rising edges, released just after the last one
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/ibuf_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ibuf_tb;

    localparam int CLK_PERIOD_NS   = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 200;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int WATCHDOG_NS     =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD_NS + 1000;

    logic                                       clk;
    logic                                       rst_n;
    ibuf_pkg::fetch_pair_t                      fetch;
    ibuf_pkg::redirect_t                        redirect;
    logic                                       consume;
    logic [3:0]                                 consume_len;
    ibuf_pkg::line_t [ibuf_pkg::NUM_SLOTS-1:0]  lines;
    logic [ibuf_pkg::NUM_SLOTS-1:0]             valid;
    logic [ibuf_pkg::BIP_BITS-1:0]              bip;
    logic                                       even_loaded;
    logic                                       odd_loaded;

    string       test_name = "reset";
    logic [31:0] lcg_state = 32'd53841;

    // reference model state
    logic [3:0]            m_valid;
    ibuf_pkg::line_t [3:0] m_lines;
    logic [5:0]            m_bip;
    logic [1:0]            m_mode;     // {even, odd}
    logic [1:0]            m_eff;
    logic [3:0]            m_wr;
    logic [3:0]            m_free;
    logic [1:0]            m_loaded;
    logic [5:0]            m_next_bip;
    logic                  m_flush;
    logic                  wrap_now;
    logic [1:0]            left_slot;
    logic [3:0]            pos_mask;

    ibuf_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    ibuf_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (fetch),
        .redirect    (redirect),
        .consume     (consume),
        .consume_len (consume_len),
        .lines       (lines),
        .valid       (valid),
        .bip         (bip),
        .even_loaded (even_loaded),
        .odd_loaded  (odd_loaded)
    );

    bind ibuf_load_ctrl ibuf_props u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect  (redirect),
        .even_miss (even_miss),
        .odd_miss  (odd_miss),
        .load_mode (load_mode),
        .mode_q    (mode_q)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [511:0] slot_mask(input logic [3:0] v);
        logic [511:0] m;
        m = '0;
        for (int i = 0; i < 4; i++) begin
            if (v[i]) m[i*128 +: 128] = '1;
        end
        return m;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string check, input string expected,
                                   input string actual);
        abort_run($sformatf("** Error [%s] %s: expected %s, actual %s",
                            test_name, check, expected, actual));
    endtask

    task automatic present_lines();
        logic [31:0] r;
        r = lcg_next();
        fetch.even_line = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        fetch.odd_line  = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        fetch.even_pos  = {r[0], 1'b0};
        fetch.odd_pos   = {r[1], 1'b1};
        fetch.even_miss = 1'b0;
        fetch.odd_miss  = 1'b0;
    endtask

    // hold the current inputs over one edge, then go back to idle strobes
    task automatic step();
        @(posedge clk);
        #1;
        redirect = '0;
        consume  = 1'b0;
        present_lines();
    endtask

    always_comb begin
        m_flush = redirect.init | redirect.resteer | redirect.br_fix;
        m_eff   = m_flush ? 2'b11 : m_mode;
        m_eff   = m_eff & {~fetch.even_miss, ~fetch.odd_miss};
        m_wr    = '0;
        if (m_eff[1] && (m_flush || !m_valid[fetch.even_pos])) m_wr[fetch.even_pos] = 1'b1;
        if (m_eff[0] && (m_flush || !m_valid[fetch.odd_pos])) m_wr[fetch.odd_pos] = 1'b1;
        m_loaded   = {m_wr[0] | m_wr[2], m_wr[1] | m_wr[3]};
        m_next_bip = m_bip + {2'b00, consume_len};
        left_slot  = m_bip[5:4];
        wrap_now   = consume && (m_next_bip[3:0] < m_bip[3:0]);
        m_free     = m_flush ? 4'hf : (wrap_now ? 4'b0001 << left_slot : 4'h0);
        pos_mask   = (4'b0001 << fetch.even_pos) | (4'b0001 << fetch.odd_pos);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_valid <= '0;
            m_bip   <= '0;
            m_mode  <= 2'b00;
        end else begin
            m_valid <= m_wr | (m_valid & ~m_free);
            if (m_flush) begin
                m_bip <= redirect.target_bip;
            end else if (consume) begin
                m_bip <= m_next_bip;
            end
            if (!fetch.even_miss && !fetch.odd_miss) begin
                m_mode <= {|(~m_valid & 4'b0101), |(~m_valid & 4'b1010)};
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (m_wr[i]) m_lines[i] <= i[0] ? fetch.odd_line : fetch.even_line;
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (!rst_n) valid === m_valid)
        else report_mismatch("valid", $sformatf("%h", $sampled(m_valid)),
                             $sformatf("%h", $sampled(valid)));
    a_bip: assert property (@(posedge clk) disable iff (!rst_n) bip === m_bip)
        else report_mismatch("bip", $sformatf("%h", $sampled(m_bip)),
                             $sformatf("%h", $sampled(bip)));
    a_lines: assert property (@(posedge clk) disable iff (!rst_n)
        (lines & slot_mask(m_valid)) === (m_lines & slot_mask(m_valid)))
        else report_mismatch("lines", $sformatf("%h", $sampled(m_lines)),
                             $sformatf("%h", $sampled(lines)));
    a_loaded: assert property (@(posedge clk) disable iff (!rst_n)
        {even_loaded, odd_loaded} === m_loaded)
        else report_mismatch("even/odd loaded", $sformatf("%b", $sampled(m_loaded)),
                             $sformatf("%b", $sampled({even_loaded, odd_loaded})));
    a_even_miss: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.even_miss |-> !even_loaded)
        else report_mismatch("even_loaded on miss", "0", "1");
    a_odd_miss: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.odd_miss |-> !odd_loaded)
        else report_mismatch("odd_loaded on miss", "0", "1");
    // valid slots keep their bytes unless a flush rewrites them
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !m_flush |=> ((lines ^ $past(lines)) & slot_mask($past(valid))) == '0)
        else report_mismatch("stable line", $sformatf("%h", $sampled(m_lines)),
                             $sformatf("%h", $sampled(lines)));
    a_no_free: assert property (@(posedge clk) disable iff (!rst_n)
        (consume && !m_flush && !wrap_now) |=> (valid & $past(valid)) == $past(valid))
        else report_mismatch("no free", $sformatf("%h", $sampled(m_valid)),
                             $sformatf("%h", $sampled(valid)));
    a_wrap_free: assert property (@(posedge clk) disable iff (!rst_n)
        (consume && !m_flush && wrap_now && !m_wr[left_slot]) |=> !valid[$past(left_slot)])
        else report_mismatch("freed slot", $sformatf("%h", $sampled(m_valid)),
                             $sformatf("%h", $sampled(valid)));
    a_flush_valid: assert property (@(posedge clk) disable iff (!rst_n)
        m_flush |=> valid == $past(m_wr))
        else report_mismatch("flush valid", $sformatf("%h", $sampled(m_valid)),
                             $sformatf("%h", $sampled(valid)));
    a_flush_bip: assert property (@(posedge clk) disable iff (!rst_n)
        m_flush |=> bip == $past(redirect.target_bip))
        else report_mismatch("flush bip", $sformatf("%h", $sampled(m_bip)),
                             $sformatf("%h", $sampled(bip)));
    a_init: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect.init && !fetch.even_miss && !fetch.odd_miss) |=> valid == $past(pos_mask))
        else report_mismatch("init valid", $sformatf("%h", $sampled(m_valid)),
                             $sformatf("%h", $sampled(valid)));

    always @(uut.u_load_ctrl.u_props.fail_count) begin
        if (uut.u_load_ctrl.u_props.fail_count != 0) begin
            abort_run("a bound property on ibuf_load_ctrl failed");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog: the run did not finish within its time limit");
    end

    initial begin
        logic [31:0] r;
        fetch       = '0;
        redirect    = '0;
        consume     = 1'b0;
        consume_len = 4'd1;
        wait (rst_n === 1'b1);
        present_lines();
        step();

        test_name = "init";
        redirect.init       = 1'b1;
        redirect.target_bip = 6'd37;
        step();
        step();

        test_name = "fill";
        while (valid != 4'hf) begin
            step();
        end
        repeat (4) step();   // full, nothing may move

        test_name = "miss";
        for (int i = 0; i < 24; i++) begin
            fetch.even_miss = (i % 3 == 0);
            fetch.odd_miss  = (i % 4 == 1);
            if (i == 0) redirect.resteer = 1'b1;
            step();
        end

        test_name = "retire";
        for (int i = 0; i < 64; i++) begin
            consume     = 1'b1;
            consume_len = 4'((lcg_next() % 32'd15) + 32'd1);
            step();
        end

        test_name = "flush";
        redirect.br_fix     = 1'b1;
        redirect.target_bip = 6'(lcg_next());
        step();
        repeat (3) step();
        redirect.resteer    = 1'b1;
        redirect.target_bip = 6'(lcg_next());
        consume             = 1'b1;   // flush beats the consume
        consume_len         = 4'd15;
        step();
        repeat (3) step();

        test_name = "random";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r = lcg_next();
            fetch.even_miss = (r[2:0] == 3'd0);
            fetch.odd_miss  = (r[5:3] == 3'd0);
            consume         = r[6];
            consume_len     = 4'((lcg_next() % 32'd15) + 32'd1);
            if (r[12:8] == 5'd0) begin
                redirect.init       = (r[14:13] == 2'd0);
                redirect.resteer    = (r[14:13] == 2'd1);
                redirect.br_fix     = r[14];
                redirect.target_bip = r[20:15];
            end
            step();
        end

        test_name = "end";
        step();
        if (uut.u_load_ctrl.u_props.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run("a bound property on ibuf_load_ctrl failed");
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
source/ibuf_pkg.sv
source/ibuf_load_ctrl.sv
source/ibuf_slot_select.sv
source/ibuf_retire_track.sv
source/ibuf_line_store.sv
source/ibuf_top.sv
verification/ibuf_props.sv
verification/ibuf_clk_gen.sv
verification/ibuf_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = ibuf_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
RUN_FLAGS = +verilator+error+limit+10
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
